// File: Makefile
# Verilator build and run for the host peripheral block

VERILATOR ?= verilator
TOP       ?= tb_periph_soc
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= All tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) verification/tb_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+verification
rtl/periph_pkg.sv
rtl/bus_decode.sv
rtl/ctrl_regs.sv
rtl/sync_fifo.sv
rtl/readback_mux.sv
rtl/periph_soc.sv
verification/tb_periph_soc.sv

// File: rtl/bus_decode.sv
/*
 * Host bus decoder.
 * Splits the bus into its four regions and routes the
 * strobes and data words to the keyboard, tx and rx FIFO
 * channels, plus the SD register write strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module bus_decode
  (
  input  wire                     hid_req_i,
  input  wire                     hid_we_i,
  input  wire periph_pkg::bus_addr_t hid_addr_i,
  input  wire periph_pkg::word_t  hid_wrdata_i,
  input  wire                     key_valid_i,
  input  wire [6:0]               key_ascii_i,
  input  wire [7:0]               key_scan_i,
  input  wire                     tx_rd_i,
  input  wire                     rx_wr_i,
  input  wire periph_pkg::word_t  rx_data_i,
  input  wire                     data_rst_i,
  output logic                    reg_we_o,
  output periph_pkg::reg_off_t    reg_off_o,
  output periph_pkg::region_t     region_o,
  output logic [periph_pkg::NUM_FIFO-1:0] fifo_push_o,
  output logic [periph_pkg::NUM_FIFO-1:0] fifo_pop_o,
  output periph_pkg::word_t       fifo_din_o [periph_pkg::NUM_FIFO],
  output logic [periph_pkg::NUM_FIFO-1:0] fifo_clear_o
  );

  import periph_pkg::*;

  logic bus_wr;
  logic sd_sel;
  logic tx_sel;

  assign region_o  = hid_addr_i[16:15];
  assign reg_off_o = hid_addr_i[6:2];

  assign bus_wr = hid_req_i & hid_we_i;
  assign sd_sel = (region_o == REGION_SD);
  assign tx_sel = hid_addr_i[SD_TX_BIT];

  // register bank only sees the lower half of region 2
  assign reg_we_o = bus_wr & sd_sel & ~tx_sel;

  // keyboard events, popped by a host write to region 0
  assign fifo_push_o[CH_KEYB]  = key_valid_i;
  assign fifo_pop_o[CH_KEYB]   = bus_wr & (region_o == REGION_KEYB);
  assign fifo_din_o[CH_KEYB]   = {17'b0, key_ascii_i, key_scan_i};
  assign fifo_clear_o[CH_KEYB] = 1'b0;  // only rstn empties it

  // host to card
  assign fifo_push_o[CH_TX]  = bus_wr & sd_sel & tx_sel;
  assign fifo_pop_o[CH_TX]   = tx_rd_i;
  assign fifo_din_o[CH_TX]   = hid_wrdata_i;
  assign fifo_clear_o[CH_TX] = ~data_rst_i;  // held clear while data reset low

  // card to host
  assign fifo_push_o[CH_RX]  = rx_wr_i;
  assign fifo_pop_o[CH_RX]   = bus_wr & (region_o == REGION_RX);
  assign fifo_din_o[CH_RX]   = rx_data_i;
  assign fifo_clear_o[CH_RX] = ~data_rst_i;

endmodule

`default_nettype wire

// File: rtl/ctrl_regs.sv
/*
 * SD control register bank.
 * Holds the writable SD command and data settings, the
 * reset bits and the LED register, and samples the DIP
 * switches and the card detect input every cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs
  (
  input  wire                    msoc_clk,
  input  wire                    rstn,
  input  wire                    reg_we_i,
  input  wire periph_pkg::reg_off_t reg_off_i,
  input  wire periph_pkg::word_t hid_wrdata_i,
  input  wire [15:0]             from_dip_i,
  input  wire                    sd_detect_i,
  output logic                   sd_reset_o,
  output logic                   sd_clk_rst_o,
  output logic                   sd_cmd_rst_o,
  output logic [1:0]             sd_align_o,
  output periph_pkg::word_t      sd_cmd_arg_o,
  output logic [5:0]             sd_cmd_index_o,
  output logic [2:0]             sd_cmd_setting_o,
  output logic [2:0]             sd_data_start_o,
  output logic                   sd_cmd_start_o,
  output logic [15:0]            sd_blkcnt_o,
  output logic [11:0]            sd_blksize_o,
  output periph_pkg::word_t      sd_cmd_timeout_o,
  output logic [7:0]             to_led_o,
  output logic                   data_rst_o,
  output logic [15:0]            dip_o,
  output logic                   detect_o
  );

  import periph_pkg::*;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sd_reset_o       <= 1'b0;
      sd_clk_rst_o     <= 1'b0;
      sd_cmd_rst_o     <= 1'b0;
      data_rst_o       <= 1'b0;
      sd_align_o       <= '0;
      sd_cmd_arg_o     <= '0;
      sd_cmd_index_o   <= '0;
      sd_cmd_setting_o <= '0;
      sd_data_start_o  <= '0;
      sd_cmd_start_o   <= 1'b0;
      sd_blkcnt_o      <= '0;
      sd_blksize_o     <= '0;
      sd_cmd_timeout_o <= '0;
      to_led_o         <= '0;
    end
    else if (reg_we_i)
    begin
      case (reg_off_i)
        OFF_ALIGN:     sd_align_o     <= hid_wrdata_i[1:0];
        OFF_ARG:       sd_cmd_arg_o   <= hid_wrdata_i;
        OFF_CMD_INDEX: sd_cmd_index_o <= hid_wrdata_i[5:0];
        OFF_SETTING:
        begin
          sd_data_start_o  <= hid_wrdata_i[5:3];
          sd_cmd_setting_o <= hid_wrdata_i[2:0];
        end
        OFF_START:     sd_cmd_start_o <= hid_wrdata_i[0];  // level, not a pulse
        OFF_RESETS:
        begin
          sd_reset_o   <= hid_wrdata_i[3];
          sd_clk_rst_o <= hid_wrdata_i[2];
          data_rst_o   <= hid_wrdata_i[1];  // low keeps data FIFOs cleared
          sd_cmd_rst_o <= hid_wrdata_i[0];
        end
        OFF_BLKCNT:    sd_blkcnt_o      <= hid_wrdata_i[15:0];
        OFF_BLKSIZE:   sd_blksize_o     <= hid_wrdata_i[11:0];
        OFF_TIMEOUT:   sd_cmd_timeout_o <= hid_wrdata_i;
        OFF_LED:       to_led_o         <= hid_wrdata_i[7:0];  // card activity etc
        default:
        begin
        end
      endcase
    end
  end

  // board inputs, sampled every cycle
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      dip_o    <= '0;
      detect_o <= 1'b0;
    end
    else
    begin
      dip_o    <= from_dip_i;
      detect_o <= sd_detect_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/periph_pkg.sv
/*
 * Shared definitions for the host peripheral block.
 * Word, address and count types, bus region codes,
 * FIFO channel indices and sizing, and the SD register map.
 */
`default_nettype none

package periph_pkg;

  typedef logic [31:0] word_t;      // bus data word
  typedef logic [16:0] bus_addr_t;  // word aligned byte address
  typedef logic [1:0]  region_t;    // address bits 16:15
  typedef logic [4:0]  reg_off_t;   // address bits 6:2
  typedef logic [4:0]  fifo_cnt_t;  // 0 to 16 words

  localparam region_t REGION_KEYB  = 2'd0;
  localparam region_t REGION_FRAME = 2'd1;  // frame store, reads zero
  localparam region_t REGION_SD    = 2'd2;
  localparam region_t REGION_RX    = 2'd3;

  localparam int SD_TX_BIT = 14;  // tx FIFO push within region 2

  localparam int NUM_FIFO = 3;
  localparam int CH_KEYB  = 0;
  localparam int CH_TX    = 1;
  localparam int CH_RX    = 2;

  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_ALMOST = 14;

  // writable SD control registers
  localparam reg_off_t OFF_ALIGN     = 5'd0;
  localparam reg_off_t OFF_ARG       = 5'd2;
  localparam reg_off_t OFF_CMD_INDEX = 5'd3;
  localparam reg_off_t OFF_SETTING   = 5'd4;  // data start and cmd setting
  localparam reg_off_t OFF_START     = 5'd5;
  localparam reg_off_t OFF_RESETS    = 5'd6;
  localparam reg_off_t OFF_BLKCNT    = 5'd7;
  localparam reg_off_t OFF_BLKSIZE   = 5'd8;
  localparam reg_off_t OFF_TIMEOUT   = 5'd9;
  localparam reg_off_t OFF_LED       = 5'd15;

  // read window, registers read back at base plus write offset
  localparam reg_off_t RD_CARD_STATUS = 5'd5;
  localparam reg_off_t RD_RX_STATUS   = 5'd10;
  localparam reg_off_t RD_TX_STATUS   = 5'd11;
  localparam reg_off_t RD_DETECT      = 5'd12;
  localparam reg_off_t RD_REG_BASE    = 5'd16;
  localparam reg_off_t RD_DIP         = 5'd31;

  localparam word_t UNMAPPED_WORD = 32'hdeadbeef;

endpackage

`default_nettype wire

// File: rtl/periph_soc.sv
/*
 * Host peripheral block top level.
 * Bus decoder, SD control registers, keyboard/tx/rx FIFO
 * channels and the registered read data path.
 */
`timescale 1ns/1ps
`default_nettype none

module periph_soc
  (
  input  wire                    msoc_clk,
  input  wire                    rstn,
  input  wire                    hid_req_i,
  input  wire                    hid_we_i,
  input  wire periph_pkg::bus_addr_t hid_addr_i,
  input  wire periph_pkg::word_t hid_wrdata_i,
  output periph_pkg::word_t      hid_rddata_o,
  input  wire                    key_valid_i,
  input  wire [6:0]              key_ascii_i,
  input  wire [7:0]              key_scan_i,
  input  wire [15:0]             from_dip_i,
  input  wire                    sd_detect_i,
  output logic [7:0]             to_led_o,
  output logic                   sd_reset_o,
  output logic                   sd_clk_rst_o,
  output logic                   sd_cmd_rst_o,
  output logic [1:0]             sd_align_o,
  output periph_pkg::word_t      sd_cmd_arg_o,
  output logic [5:0]             sd_cmd_index_o,
  output logic [2:0]             sd_cmd_setting_o,
  output logic [2:0]             sd_data_start_o,
  output logic                   sd_cmd_start_o,
  output logic [15:0]            sd_blkcnt_o,
  output logic [11:0]            sd_blksize_o,
  output periph_pkg::word_t      sd_cmd_timeout_o,
  input  wire                    tx_rd_i,
  output periph_pkg::word_t      tx_data_o,
  output logic                   tx_empty_o,
  input  wire                    rx_wr_i,
  input  wire periph_pkg::word_t rx_data_i
  );

  import periph_pkg::*;

  logic                reg_we;
  reg_off_t            reg_off;
  region_t             region;
  logic                data_rst;
  logic [15:0]         dip;
  logic                detect;
  logic [NUM_FIFO-1:0] fifo_push, fifo_pop, fifo_clear;
  word_t               fifo_din [NUM_FIFO];
  word_t               fifo_dout [NUM_FIFO];
  fifo_cnt_t           fifo_count [NUM_FIFO];
  logic [NUM_FIFO-1:0] fifo_empty, fifo_almost_full, fifo_full;
  logic [NUM_FIFO-1:0] fifo_rd_err, fifo_wr_err;

  bus_decode u_decode (
    .hid_req_i, .hid_we_i, .hid_addr_i, .hid_wrdata_i,
    .key_valid_i, .key_ascii_i, .key_scan_i,
    .tx_rd_i, .rx_wr_i, .rx_data_i,
    .data_rst_i   (data_rst),
    .reg_we_o     (reg_we),
    .reg_off_o    (reg_off),
    .region_o     (region),
    .fifo_push_o  (fifo_push),
    .fifo_pop_o   (fifo_pop),
    .fifo_din_o   (fifo_din),
    .fifo_clear_o (fifo_clear)
  );

  ctrl_regs u_regs (
    .msoc_clk, .rstn,
    .reg_we_i (reg_we),
    .reg_off_i (reg_off),
    .hid_wrdata_i, .from_dip_i, .sd_detect_i,
    .sd_reset_o, .sd_clk_rst_o, .sd_cmd_rst_o, .sd_align_o, .sd_cmd_arg_o,
    .sd_cmd_index_o, .sd_cmd_setting_o, .sd_data_start_o, .sd_cmd_start_o,
    .sd_blkcnt_o, .sd_blksize_o, .sd_cmd_timeout_o, .to_led_o,
    .data_rst_o (data_rst),
    .dip_o      (dip),
    .detect_o   (detect)
  );

  // keyboard, tx and rx channels
  for (genvar g = 0; g < NUM_FIFO; g++)
  begin : g_fifo
    sync_fifo u_fifo (
      .msoc_clk, .rstn,
      .clear_i       (fifo_clear[g]),
      .push_i        (fifo_push[g]),
      .pop_i         (fifo_pop[g]),
      .din_i         (fifo_din[g]),
      .dout_o        (fifo_dout[g]),
      .count_o       (fifo_count[g]),
      .empty_o       (fifo_empty[g]),
      .almost_full_o (fifo_almost_full[g]),
      .full_o        (fifo_full[g]),
      .rd_err_o      (fifo_rd_err[g]),
      .wr_err_o      (fifo_wr_err[g])
    );
  end

  assign tx_data_o  = fifo_dout[CH_TX];  // SD side of tx FIFO
  assign tx_empty_o = fifo_empty[CH_TX];

  readback_mux u_rdmux (
    .msoc_clk, .rstn, .hid_req_i, .hid_we_i,
    .region_i  (region),
    .reg_off_i (reg_off),
    .sd_reset_i (sd_reset_o), .sd_clk_rst_i (sd_clk_rst_o),
    .sd_data_rst_i (data_rst), .sd_cmd_rst_i (sd_cmd_rst_o),
    .sd_align_i (sd_align_o), .sd_cmd_arg_i (sd_cmd_arg_o),
    .sd_cmd_index_i (sd_cmd_index_o), .sd_cmd_setting_i (sd_cmd_setting_o),
    .sd_data_start_i (sd_data_start_o), .sd_cmd_start_i (sd_cmd_start_o),
    .sd_blkcnt_i (sd_blkcnt_o), .sd_blksize_i (sd_blksize_o),
    .sd_cmd_timeout_i (sd_cmd_timeout_o),
    .dip_i (dip), .detect_i (detect),
    .fifo_dout_i (fifo_dout), .fifo_count_i (fifo_count),
    .fifo_empty_i (fifo_empty), .fifo_almost_full_i (fifo_almost_full),
    .fifo_full_i (fifo_full), .fifo_rd_err_i (fifo_rd_err),
    .fifo_wr_err_i (fifo_wr_err),
    .hid_rddata_o
  );

endmodule

`default_nettype wire

// File: rtl/readback_mux.sv
/*
 * Host read data path.
 * Selects keyboard head, SD register window or rx head by
 * region, packs the FIFO and card status words and registers
 * the result on each read request.
 */
`timescale 1ns/1ps
`default_nettype none

module readback_mux
  (
  input  wire                    msoc_clk,
  input  wire                    rstn,
  input  wire                    hid_req_i,
  input  wire                    hid_we_i,
  input  wire periph_pkg::region_t  region_i,
  input  wire periph_pkg::reg_off_t reg_off_i,
  input  wire                    sd_reset_i,
  input  wire                    sd_clk_rst_i,
  input  wire                    sd_data_rst_i,
  input  wire                    sd_cmd_rst_i,
  input  wire [1:0]              sd_align_i,
  input  wire periph_pkg::word_t sd_cmd_arg_i,
  input  wire [5:0]              sd_cmd_index_i,
  input  wire [2:0]              sd_cmd_setting_i,
  input  wire [2:0]              sd_data_start_i,
  input  wire                    sd_cmd_start_i,
  input  wire [15:0]             sd_blkcnt_i,
  input  wire [11:0]             sd_blksize_i,
  input  wire periph_pkg::word_t sd_cmd_timeout_i,
  input  wire [15:0]             dip_i,
  input  wire                    detect_i,
  input  wire periph_pkg::word_t fifo_dout_i [periph_pkg::NUM_FIFO],
  input  wire periph_pkg::fifo_cnt_t fifo_count_i [periph_pkg::NUM_FIFO],
  input  wire [periph_pkg::NUM_FIFO-1:0] fifo_empty_i,
  input  wire [periph_pkg::NUM_FIFO-1:0] fifo_almost_full_i,
  input  wire [periph_pkg::NUM_FIFO-1:0] fifo_full_i,
  input  wire [periph_pkg::NUM_FIFO-1:0] fifo_rd_err_i,
  input  wire [periph_pkg::NUM_FIFO-1:0] fifo_wr_err_i,
  output periph_pkg::word_t      hid_rddata_o
  );

  import periph_pkg::*;

  word_t sd_window;
  word_t rd_sel;

  // status word layout shared by rx and tx
  function automatic word_t status_word(input int ch);
    status_word = {fifo_empty_i[ch], fifo_almost_full_i[ch], fifo_full_i[ch],
                   fifo_rd_err_i[ch], fifo_wr_err_i[ch], 22'b0, fifo_count_i[ch]};
  endfunction

  always_comb
  begin
    case (reg_off_i)
      RD_CARD_STATUS: sd_window = {28'b0, fifo_full_i[CH_TX], fifo_empty_i[CH_TX],
                                   fifo_full_i[CH_RX], fifo_empty_i[CH_RX]};
      RD_RX_STATUS:   sd_window = status_word(CH_RX);
      RD_TX_STATUS:   sd_window = status_word(CH_TX);
      RD_DETECT:      sd_window = {31'b0, detect_i};
      RD_REG_BASE + OFF_ALIGN:     sd_window = {30'b0, sd_align_i};
      RD_REG_BASE + OFF_ARG:       sd_window = sd_cmd_arg_i;
      RD_REG_BASE + OFF_CMD_INDEX: sd_window = {26'b0, sd_cmd_index_i};
      RD_REG_BASE + OFF_SETTING:   sd_window = {26'b0, sd_data_start_i, sd_cmd_setting_i};
      RD_REG_BASE + OFF_START:     sd_window = {31'b0, sd_cmd_start_i};
      RD_REG_BASE + OFF_RESETS:
        sd_window = {28'b0, sd_reset_i, sd_clk_rst_i, sd_data_rst_i, sd_cmd_rst_i};
      RD_REG_BASE + OFF_BLKCNT:    sd_window = {16'b0, sd_blkcnt_i};
      RD_REG_BASE + OFF_BLKSIZE:   sd_window = {20'b0, sd_blksize_i};
      RD_REG_BASE + OFF_TIMEOUT:   sd_window = sd_cmd_timeout_i;
      RD_DIP:         sd_window = {16'b0, dip_i};  // boot options
      default:        sd_window = UNMAPPED_WORD;
    endcase

    case (region_i)
      REGION_KEYB:  rd_sel = fifo_dout_i[CH_KEYB];
      REGION_FRAME: rd_sel = '0;  // frame store gone
      REGION_SD:    rd_sel = sd_window;
      default:      rd_sel = fifo_dout_i[CH_RX];
    endcase
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
      hid_rddata_o <= '0;
    else if (hid_req_i && !hid_we_i)
      hid_rddata_o <= rd_sel;  // held until next read
  end

endmodule

`default_nettype wire

// File: rtl/sync_fifo.sv
/*
 * Single clock first-word-fall-through FIFO.
 * Circular buffer with occupancy count, almost-full and
 * full flags, and sticky overflow and underflow flags.
 */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
  #(
  parameter int DEPTH = periph_pkg::FIFO_DEPTH
  )
  (
  input  wire                    msoc_clk,
  input  wire                    rstn,
  input  wire                    clear_i,
  input  wire                    push_i,
  input  wire                    pop_i,
  input  wire periph_pkg::word_t din_i,
  output periph_pkg::word_t      dout_o,
  output periph_pkg::fifo_cnt_t  count_o,
  output logic                   empty_o,
  output logic                   almost_full_o,
  output logic                   full_o,
  output logic                   rd_err_o,
  output logic                   wr_err_o
  );

  import periph_pkg::*;

  localparam int AW = $clog2(DEPTH);

  word_t           mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic            do_push;
  logic            do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    ptr_inc = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= din_i;
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count_o  <= '0;
      rd_err_o <= 1'b0;
      wr_err_o <= 1'b0;
    end
    else if (clear_i)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count_o  <= '0;
      rd_err_o <= 1'b0;
      wr_err_o <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count_o <= count_o + fifo_cnt_t'(do_push) - fifo_cnt_t'(do_pop);
      if (push_i && full_o)
        wr_err_o <= 1'b1;  // overflow, word dropped
      if (pop_i && empty_o)
        rd_err_o <= 1'b1;
    end
  end

  assign dout_o        = mem[rd_ptr];  // head word
  assign empty_o       = (count_o == '0);
  assign full_o        = (count_o == fifo_cnt_t'(DEPTH));
  assign almost_full_o = (count_o >= fifo_cnt_t'(FIFO_ALMOST));

endmodule

`default_nettype wire

// File: verification/tb_tasks.svh
/*
 * Testbench tasks for the host peripheral block.
 * Bus and SD side drivers, address helpers, typed compare
 * tasks, and the directed tests for registers, read window,
 * keyboard, tx and rx FIFOs.
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic next_cycle();
  @(posedge msoc_clk);
  #1;  // drive point after the edge
endtask

function automatic bus_addr_t region_addr(input region_t r);
  bus_addr_t a;
  a = '0;
  a[16:15] = r;
  return a;
endfunction

function automatic bus_addr_t sd_addr(input reg_off_t off);
  bus_addr_t a;
  a = region_addr(REGION_SD);
  a[6:2] = off;
  return a;
endfunction

function automatic bus_addr_t tx_push_addr();
  bus_addr_t a;
  a = region_addr(REGION_SD);
  a[SD_TX_BIT] = 1'b1;
  return a;
endfunction

// flags are {empty, almost full, full, read error, write error}
function automatic word_t expected_status(input logic [4:0] flags, input fifo_cnt_t cnt);
  return {flags, 22'b0, cnt};
endfunction

task automatic bus_write(input bus_addr_t addr, input word_t data);
  hid_req    = 1'b1;
  hid_we     = 1'b1;
  hid_addr   = addr;
  hid_wrdata = data;
  next_cycle();
  hid_req = 1'b0;
  hid_we  = 1'b0;
endtask

task automatic bus_read(input bus_addr_t addr, output word_t data);
  hid_req  = 1'b1;
  hid_we   = 1'b0;
  hid_addr = addr;
  next_cycle();
  data    = hid_rddata;  // registered at the request edge
  hid_req = 1'b0;
endtask

task automatic rx_push(input word_t data);
  rx_wr   = 1'b1;
  rx_data = data;
  next_cycle();
  rx_wr = 1'b0;
endtask

task automatic tx_pop();
  tx_rd = 1'b1;
  next_cycle();
  tx_rd = 1'b0;
endtask

task automatic key_event(input logic [6:0] ascii, input logic [7:0] scan);
  key_valid = 1'b1;
  key_ascii = ascii;
  key_scan  = scan;
  next_cycle();
  key_valid = 1'b0;
endtask

task automatic word_equal(input string name, input word_t exp, input word_t act);
  check_total++;
  if (act !== exp)
  begin
    error_count++;
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
  end
endtask

task automatic count_equal(input string name, input fifo_cnt_t exp, input fifo_cnt_t act);
  check_total++;
  if (act !== exp)
  begin
    error_count++;
    $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
  end
endtask

task automatic bit_equal(input string name, input logic exp, input logic act);
  check_total++;
  if (act !== exp)
  begin
    error_count++;
    $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
  end
endtask

task automatic reg_write_check(input string name, input reg_off_t off, input word_t data,
                               input word_t mask);
  word_t rd;
  bus_write(sd_addr(off), data);
  bus_read(sd_addr(RD_REG_BASE + off), rd);
  word_equal(name, data & mask, rd);
endtask

task automatic registers_write_read();
  word_t d;
  word_t ctl;
  ctl = 32'({sd_reset, sd_clk_rst, sd_cmd_rst, sd_cmd_start, sd_align,
             sd_cmd_index, sd_cmd_setting, sd_data_start});
  word_equal("reset control bits", '0, ctl);
  word_equal("reset sd_blkcnt/blksize", '0, 32'({sd_blkcnt, sd_blksize}));
  word_equal("reset sd_cmd_arg_o", '0, sd_cmd_arg);
  word_equal("reset sd_cmd_timeout_o", '0, sd_cmd_timeout);
  word_equal("reset to_led_o", '0, 32'(to_led));
  word_equal("reset hid_rddata_o", '0, hid_rddata);
  bit_equal("reset tx_empty_o", 1'b1, tx_empty);
  d = $random(seed);
  reg_write_check("align readback", OFF_ALIGN, d, 32'h3);
  word_equal("sd_align_o", d & 32'h3, 32'(sd_align));
  d = $random(seed);
  reg_write_check("arg readback", OFF_ARG, d, 32'hffffffff);
  word_equal("sd_cmd_arg_o", d, sd_cmd_arg);
  d = $random(seed);
  reg_write_check("cmd index readback", OFF_CMD_INDEX, d, 32'h3f);
  word_equal("sd_cmd_index_o", d & 32'h3f, 32'(sd_cmd_index));
  d = $random(seed);
  reg_write_check("setting readback", OFF_SETTING, d, 32'h3f);
  word_equal("sd_data_start_o", 32'(d[5:3]), 32'(sd_data_start));
  word_equal("sd_cmd_setting_o", 32'(d[2:0]), 32'(sd_cmd_setting));
  d = $random(seed);
  reg_write_check("start readback", OFF_START, d, 32'h1);
  bit_equal("sd_cmd_start_o", d[0], sd_cmd_start);
  d = $random(seed);
  reg_write_check("resets readback", OFF_RESETS, d, 32'hf);
  bit_equal("sd_reset_o", d[3], sd_reset);
  bit_equal("sd_clk_rst_o", d[2], sd_clk_rst);
  bit_equal("sd_cmd_rst_o", d[0], sd_cmd_rst);
  d = $random(seed);
  reg_write_check("blkcnt readback", OFF_BLKCNT, d, 32'hffff);
  word_equal("sd_blkcnt_o", d & 32'hffff, 32'(sd_blkcnt));
  d = $random(seed);
  reg_write_check("blksize readback", OFF_BLKSIZE, d, 32'hfff);
  word_equal("sd_blksize_o", d & 32'hfff, 32'(sd_blksize));
  d = $random(seed);
  reg_write_check("timeout readback", OFF_TIMEOUT, d, 32'hffffffff);
  word_equal("sd_cmd_timeout_o", d, sd_cmd_timeout);
  d = $random(seed);
  bus_write(sd_addr(OFF_LED), d);  // write only
  word_equal("to_led_o", 32'(d[7:0]), 32'(to_led));
endtask

task automatic read_window_map();
  reg_off_t unmapped [7] = '{5'd0, 5'd1, 5'd9, 5'd14, 5'd17, 5'd26, 5'd30};
  word_t rd;
  word_t d;
  for (int i = 0; i < 7; i++)
  begin
    bus_read(sd_addr(unmapped[i]), rd);
    word_equal("unmapped offset read", 32'hdeadbeef, rd);
  end
  bus_read(region_addr(REGION_FRAME), rd);
  word_equal("frame region read", '0, rd);
  d = $random(seed);
  from_dip = d[15:0];
  next_cycle();  // let the switch sample settle
  bus_read(sd_addr(5'd31), rd);
  word_equal("dip switch read", 32'(d[15:0]), rd);
  for (int v = 1; v >= 0; v--)
  begin
    sd_detect = v[0];
    next_cycle();
    bus_read(sd_addr(5'd12), rd);
    word_equal("card detect read", 32'(v[0]), rd);
  end
endtask

task automatic tx_fifo_order();
  word_t rd;
  word_t d;
  word_t exp_q [$];
  bus_write(sd_addr(OFF_RESETS), 32'h0);  // data reset low
  repeat (3) bus_write(tx_push_addr(), $random(seed));
  bit_equal("tx_empty_o while cleared", 1'b1, tx_empty);
  bus_read(sd_addr(RD_TX_STATUS), rd);
  word_equal("tx status while cleared", expected_status(5'b10000, 5'd0), rd);
  bus_write(sd_addr(OFF_RESETS), 32'h2);
  for (int i = 0; i < 8; i++)
  begin
    d = $random(seed);
    exp_q.push_back(d);
    bus_write(tx_push_addr(), d);
  end
  bus_read(sd_addr(RD_TX_STATUS), rd);
  word_equal("tx status", expected_status(5'b00000, 5'd8), rd);
  count_equal("tx count", 5'd8, rd[4:0]);
  while (exp_q.size() > 0)
  begin
    bit_equal("tx_empty_o", 1'b0, tx_empty);
    word_equal("tx_data_o", exp_q.pop_front(), tx_data);
    tx_pop();
  end
  bit_equal("tx_empty_o drained", 1'b1, tx_empty);
endtask

task automatic rx_fifo_order();
  word_t rd;
  word_t d;
  word_t exp_q [$];
  bus_read(sd_addr(RD_CARD_STATUS), rd);
  word_equal("card status, both empty", 32'h5, rd);
  for (int i = 0; i < 5; i++)
  begin
    d = $random(seed);
    exp_q.push_back(d);
    rx_push(d);
  end
  bus_read(sd_addr(RD_CARD_STATUS), rd);
  word_equal("card status, rx holds data", 32'h4, rd);
  while (exp_q.size() > 0)
  begin
    bus_read(region_addr(REGION_RX), rd);
    word_equal("rx head", exp_q.pop_front(), rd);
    bus_write(region_addr(REGION_RX), 32'h0);  // pop
  end
  bus_read(sd_addr(RD_CARD_STATUS), rd);
  word_equal("card status, rx drained", 32'h5, rd);
endtask

task automatic keyboard_events();
  word_t rd;
  word_t d;
  word_t exp_q [$];
  for (int i = 0; i < 4; i++)
  begin
    d = $random(seed);
    exp_q.push_back({17'b0, d[6:0], d[15:8]});
    key_event(d[6:0], d[15:8]);
  end
  while (exp_q.size() > 0)
  begin
    bus_read(region_addr(REGION_KEYB), rd);
    word_equal("keyboard head", exp_q.pop_front(), rd);
    bus_write(region_addr(REGION_KEYB), 32'h0);
  end
endtask

task automatic rx_overflow_underflow();
  word_t rd;
  word_t d;
  word_t exp_q [$];
  for (int i = 0; i < 17; i++)
  begin
    d = $random(seed);
    if (i < 16)
      exp_q.push_back(d);  // the 17th word is dropped
    rx_push(d);
  end
  bus_read(sd_addr(RD_RX_STATUS), rd);
  word_equal("rx status when full", expected_status(5'b01101, 5'd16), rd);
  count_equal("rx count when full", 5'd16, rd[4:0]);
  bus_read(sd_addr(RD_CARD_STATUS), rd);
  word_equal("card status, rx full", 32'h6, rd);
  while (exp_q.size() > 0)
  begin
    bus_read(region_addr(REGION_RX), rd);
    word_equal("rx head after overflow", exp_q.pop_front(), rd);
    bus_write(region_addr(REGION_RX), 32'h0);
  end
  bus_write(region_addr(REGION_RX), 32'h0);  // one pop too many
  bus_read(sd_addr(RD_RX_STATUS), rd);
  word_equal("rx status after underflow", expected_status(5'b10011, 5'd0), rd);
endtask

`endif

// File: verification/tb_periph_soc.sv
/*
 * Testbench top for the host peripheral block.
 * Clock and reset generation, DUT instance, watchdog
 * and the directed test sequence with the result line.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_periph_soc;

  import periph_pkg::*;

  localparam int CLK_PERIOD  = 10;
  // reset, then registers, window, tx, rx, keyboard, overflow
  localparam int TEST_CYCLES = 5 + 20 + 15 + 25 + 20 + 15 + 55;

  logic        msoc_clk;
  logic        rstn;
  logic        hid_req;
  logic        hid_we;
  bus_addr_t   hid_addr;
  word_t       hid_wrdata;
  word_t       hid_rddata;
  logic        key_valid;
  logic [6:0]  key_ascii;
  logic [7:0]  key_scan;
  logic [15:0] from_dip;
  logic        sd_detect;
  logic [7:0]  to_led;
  logic        sd_reset;
  logic        sd_clk_rst;
  logic        sd_cmd_rst;
  logic [1:0]  sd_align;
  word_t       sd_cmd_arg;
  logic [5:0]  sd_cmd_index;
  logic [2:0]  sd_cmd_setting;
  logic [2:0]  sd_data_start;
  logic        sd_cmd_start;
  logic [15:0] sd_blkcnt;
  logic [11:0] sd_blksize;
  word_t       sd_cmd_timeout;
  logic        tx_rd;
  word_t       tx_data;
  logic        tx_empty;
  logic        rx_wr;
  word_t       rx_data;

  integer seed;
  int     error_count;
  int     check_total;

  periph_soc UUT (
    .msoc_clk         (msoc_clk),
    .rstn             (rstn),
    .hid_req_i        (hid_req),
    .hid_we_i         (hid_we),
    .hid_addr_i       (hid_addr),
    .hid_wrdata_i     (hid_wrdata),
    .hid_rddata_o     (hid_rddata),
    .key_valid_i      (key_valid),
    .key_ascii_i      (key_ascii),
    .key_scan_i       (key_scan),
    .from_dip_i       (from_dip),
    .sd_detect_i      (sd_detect),
    .to_led_o         (to_led),
    .sd_reset_o       (sd_reset),
    .sd_clk_rst_o     (sd_clk_rst),
    .sd_cmd_rst_o     (sd_cmd_rst),
    .sd_align_o       (sd_align),
    .sd_cmd_arg_o     (sd_cmd_arg),
    .sd_cmd_index_o   (sd_cmd_index),
    .sd_cmd_setting_o (sd_cmd_setting),
    .sd_data_start_o  (sd_data_start),
    .sd_cmd_start_o   (sd_cmd_start),
    .sd_blkcnt_o      (sd_blkcnt),
    .sd_blksize_o     (sd_blksize),
    .sd_cmd_timeout_o (sd_cmd_timeout),
    .tx_rd_i          (tx_rd),
    .tx_data_o        (tx_data),
    .tx_empty_o       (tx_empty),
    .rx_wr_i          (rx_wr),
    .rx_data_i        (rx_data)
  );

  `include "tb_tasks.svh"

  always #(CLK_PERIOD / 2) msoc_clk = ~msoc_clk;

  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);  // twice the expected run length
    $display("watchdog expired before the test sequence finished");
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    seed        = 32'h6a07b6b7;
    error_count = 0;
    check_total = 0;
    msoc_clk    = 1'b0;
    rstn        = 1'b0;
    hid_req     = 1'b0;
    hid_we      = 1'b0;
    hid_addr    = '0;
    hid_wrdata  = '0;
    key_valid   = 1'b0;
    key_ascii   = '0;
    key_scan    = '0;
    from_dip    = '0;
    sd_detect   = 1'b0;
    tx_rd       = 1'b0;
    rx_wr       = 1'b0;
    rx_data     = '0;
    repeat (4) @(posedge msoc_clk);
    #1;
    rstn = 1'b1;

    registers_write_read();
    read_window_map();
    tx_fifo_order();
    rx_fifo_order();
    keyboard_events();
    rx_overflow_underflow();

    $display("checks run: %0d, errors: %0d", check_total, error_count);
    if (error_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
